// File: common/collectorPkg.sv
package collectorPkg;

    // address layout
    localparam int ADDR_WIDTH       = 12;
    localparam int BANK_ADDR_WIDTH  = 10;
    localparam int BANK_COUNT       = 4;
    localparam int BANK_SEL_WIDTH   = ADDR_WIDTH - BANK_ADDR_WIDTH;
    localparam int BANK_DEPTH       = 1 << BANK_ADDR_WIDTH;

    // slot layout, two slots per memory word
    localparam int SLOT_COUNT       = 6;
    localparam int SLOT_INDEX_WIDTH = 3;
    localparam int SLOTS_PER_RAM    = 2;
    localparam int RAMS_PER_BANK    = SLOT_COUNT / SLOTS_PER_RAM;

    // data widths
    localparam int EXP_WIDTH        = 6;
    localparam int TERM_WIDTH       = 36;
    localparam int SUM_WIDTH        = 39;
    localparam int COUNT_WIDTH      = 3;

    // pipeline timing
    localparam int RAM_READ_CYCLES  = 2;
    localparam int SUM_STAGES       = 2;
    localparam int READ_LATENCY     = RAM_READ_CYCLES + 1 + SUM_STAGES;

    typedef struct packed {
        logic                 occupied;
        logic [EXP_WIDTH-1:0] exponent;
    } slotEntryT;

    typedef slotEntryT [SLOTS_PER_RAM-1:0] slotPairT;
    typedef slotEntryT [SLOT_COUNT-1:0] rowT;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0]       rowAddr;
        logic [SLOT_INDEX_WIDTH-1:0] slotIndex;
        logic [EXP_WIDTH-1:0]        exponent;
    } collectWriteT;

    typedef struct packed {
        logic [SLOT_COUNT-1:0][TERM_WIDTH-1:0] terms;
        logic [COUNT_WIDTH-1:0]                count;
        logic                                  valid;
    } decodedRowT;

    typedef struct packed {
        logic [SUM_WIDTH-1:0]   sum;
        logic [COUNT_WIDTH-1:0] count;
    } collectResultT;

endpackage

// File: collector/maskedDualPortRam.sv
`timescale 1ns/1ps

module maskedDualPortRam import collectorPkg::*; (
    input  logic                       clk,
    input  logic                       writeEnable,
    input  logic [BANK_ADDR_WIDTH-1:0] writeAddr,
    input  logic [SLOTS_PER_RAM-1:0]   writeMask,
    input  slotPairT                   writeData,
    input  logic                       readEnable,
    input  logic [BANK_ADDR_WIDTH-1:0] readAddr,
    output slotPairT                   readData
);

    slotPairT mem [BANK_DEPTH];
    slotPairT readStage;
    logic     readPending;

    // masked write, one enable per slot half
    always_ff @(posedge clk) begin
        if (writeEnable) begin
            for (int h = 0; h < SLOTS_PER_RAM; h++) begin
                if (writeMask[h]) begin
                    mem[writeAddr][h] <= writeData[h];
                end
            end
        end
    end

    // two-stage read, output register idles at zero
    always_ff @(posedge clk) begin
        readPending <= readEnable;
        if (readEnable) begin
            readStage <= mem[readAddr];
        end
        if (readPending) begin
            readData <= readStage;
        end else begin
            readData <= '0;
        end
    end

endmodule

// File: collector/collectorBank.sv
`timescale 1ns/1ps

module collectorBank import collectorPkg::*; (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       writeEnable,
    input  logic [BANK_ADDR_WIDTH-1:0] writeAddr,
    input  logic [SLOT_COUNT-1:0]      slotMask,
    input  slotEntryT                  writeEntry,
    input  logic                       readEnable,
    input  logic [BANK_ADDR_WIDTH-1:0] readAddr,
    output rowT                        readRow
);

    logic                       pendWrite;
    logic [BANK_ADDR_WIDTH-1:0] pendAddr;
    logic [SLOT_COUNT-1:0]      pendMask;
    slotEntryT                  pendEntry;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pendWrite <= 1'b0;
        end else begin
            pendWrite <= writeEnable | readEnable;
        end
    end

    // a read takes over the deferred port to wipe its own row
    always_ff @(posedge clk) begin
        if (readEnable) begin
            pendAddr  <= readAddr;
            pendMask  <= '1;
            pendEntry <= '0;
        end else begin
            pendAddr  <= writeAddr;
            pendMask  <= slotMask;
            pendEntry <= writeEntry;
        end
    end

    for (genvar r = 0; r < RAMS_PER_BANK; r++) begin : g_ram
        maskedDualPortRam ramInst (
            .clk        (clk),
            .writeEnable(pendWrite),
            .writeAddr  (pendAddr),
            .writeMask  (pendMask[SLOTS_PER_RAM*r +: SLOTS_PER_RAM]),
            .writeData  ({pendEntry, pendEntry}),
            .readEnable (readEnable),
            .readAddr   (readAddr),
            .readData   (readRow[SLOTS_PER_RAM*r +: SLOTS_PER_RAM])
        );
    end

endmodule

// File: collector/collectionArray.sv
`timescale 1ns/1ps

module collectionArray import collectorPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  writeValid,
    input  collectWriteT          writeReq,
    input  logic                  readValid,
    input  logic [ADDR_WIDTH-1:0] readAddr,
    output rowT                   rowData,
    output logic                  rowValid
);

    slotEntryT                   newEntry;
    logic [SLOT_COUNT-1:0]       newMask;
    logic [BANK_SEL_WIDTH-1:0]   writeBank;
    logic [BANK_SEL_WIDTH-1:0]   readBank;
    rowT                         bankRows [BANK_COUNT];
    logic [RAM_READ_CYCLES-1:0]  validPipe;

    assign newEntry.occupied = 1'b1;
    assign newEntry.exponent = writeReq.exponent;
    // slot indices past the last slot shift out and write nothing
    assign newMask   = SLOT_COUNT'(1) << writeReq.slotIndex;
    assign writeBank = writeReq.rowAddr[ADDR_WIDTH-1:BANK_ADDR_WIDTH];
    assign readBank  = readAddr[ADDR_WIDTH-1:BANK_ADDR_WIDTH];

    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
        collectorBank bankInst (
            .clk        (clk),
            .rstN       (rstN),
            .writeEnable(writeValid && (writeBank == BANK_SEL_WIDTH'(b))),
            .writeAddr  (writeReq.rowAddr[BANK_ADDR_WIDTH-1:0]),
            .slotMask   (newMask),
            .writeEntry (newEntry),
            .readEnable (readValid && (readBank == BANK_SEL_WIDTH'(b))),
            .readAddr   (readAddr[BANK_ADDR_WIDTH-1:0]),
            .readRow    (bankRows[b])
        );
    end

    // idle banks return zero so a plain OR picks the read one
    always_comb begin
        rowData = '0;
        for (int b = 0; b < BANK_COUNT; b++) begin
            rowData = rowData | bankRows[b];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[RAM_READ_CYCLES-2:0], readValid};
        end
    end

    assign rowValid = validPipe[RAM_READ_CYCLES-1];

endmodule

// File: source/slotDecoder.sv
`timescale 1ns/1ps

module slotDecoder import collectorPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  rowT        rowData,
    input  logic       rowValid,
    output decodedRowT decoded
);

    logic [SLOT_COUNT-1:0][TERM_WIDTH-1:0] termsNext;
    logic [SLOT_COUNT-1:0][TERM_WIDTH-1:0] termsQ;
    logic [COUNT_WIDTH-1:0]                countNext;
    logic [COUNT_WIDTH-1:0]                countQ;
    logic                                  validQ;

    always_comb begin
        countNext = '0;
        for (int i = 0; i < SLOT_COUNT; i++) begin
            // empty slot adds nothing
            termsNext[i] = rowData[i].occupied ? (TERM_WIDTH'(1) << rowData[i].exponent) : '0;
            countNext    = countNext + COUNT_WIDTH'(rowData[i].occupied);
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= rowValid;
        end
    end

    always_ff @(posedge clk) begin
        termsQ <= termsNext;
        countQ <= countNext;
    end

    assign decoded = '{terms: termsQ, count: countQ, valid: validQ};

endmodule

// File: source/termSummer.sv
`timescale 1ns/1ps

module termSummer import collectorPkg::*; (
    input  logic          clk,
    input  logic          rstN,
    input  decodedRowT    decoded,
    output logic          resultValid,
    output collectResultT result
);

    localparam int PAIR_COUNT = SLOT_COUNT / 2;

    logic [TERM_WIDTH:0]    pairSum [PAIR_COUNT];
    logic [COUNT_WIDTH-1:0] pairCount;
    logic                   pairValid;
    logic [SUM_WIDTH-1:0]   sumQ;
    logic [COUNT_WIDTH-1:0] countQ;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pairValid   <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            pairValid   <= decoded.valid;
            resultValid <= pairValid;
        end
    end

    // stage one adds neighbouring terms, stage two the three partials
    always_ff @(posedge clk) begin
        for (int p = 0; p < PAIR_COUNT; p++) begin
            pairSum[p] <= (TERM_WIDTH+1)'(decoded.terms[2*p])
                        + (TERM_WIDTH+1)'(decoded.terms[2*p+1]);
        end
        pairCount <= decoded.count;
        sumQ      <= SUM_WIDTH'(pairSum[0]) + SUM_WIDTH'(pairSum[1])
                   + SUM_WIDTH'(pairSum[2]);
        countQ    <= pairCount;
    end

    assign result = '{sum: sumQ, count: countQ};

endmodule

// File: source/collectorTop.sv
`timescale 1ns/1ps

module collectorTop import collectorPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  writeValid,
    input  collectWriteT          writeReq,
    input  logic                  readValid,
    input  logic [ADDR_WIDTH-1:0] readAddr,
    output logic                  resultValid,
    output collectResultT         result
);

    rowT        rowData;
    logic       rowValid;
    decodedRowT decoded;

    collectionArray arrayInst (
        .clk       (clk),
        .rstN      (rstN),
        .writeValid(writeValid),
        .writeReq  (writeReq),
        .readValid (readValid),
        .readAddr  (readAddr),
        .rowData   (rowData),
        .rowValid  (rowValid)
    );

    slotDecoder decoderInst (
        .clk     (clk),
        .rstN    (rstN),
        .rowData (rowData),
        .rowValid(rowValid),
        .decoded (decoded)
    );

    termSummer summerInst (
        .clk        (clk),
        .rstN       (rstN),
        .decoded    (decoded),
        .resultValid(resultValid),
        .result     (result)
    );

endmodule

// File: tb/collectorTop_checker.sv
`timescale 1ns/1ps

module collectorTopChecker import collectorPkg::*; (
    input logic          clk,
    input logic          rstN,
    input logic          writeValid,
    input collectWriteT  writeReq,
    input logic          readValid,
    input logic          resultValid,
    input collectResultT result
);

    // every read answers exactly once, READ_LATENCY cycles later
    readToResult: assert property (@(posedge clk) disable iff (!rstN)
        readValid |-> ##READ_LATENCY resultValid)
        else $error("no result %0d cycles after a read", READ_LATENCY);

    resultFromRead: assert property (@(posedge clk) disable iff (!rstN)
        resultValid |-> $past(readValid, READ_LATENCY))
        else $error("result without a matching read");

    // a sum of count powers of two has at most count bits set, zero only when empty
    countRange: assert property (@(posedge clk) disable iff (!rstN)
        resultValid |-> result.count <= COUNT_WIDTH'(SLOT_COUNT)
                        && $countones(result.sum) <= result.count
                        && ((result.sum == '0) == (result.count == '0)))
        else $error("occupancy count %0d does not fit sum %0h", result.count, result.sum);

    exponentRange: assert property (@(posedge clk) disable iff (!rstN)
        writeValid |-> writeReq.exponent <= EXP_WIDTH'(TERM_WIDTH - 1))
        else $error("write exponent %0d out of range", writeReq.exponent);

endmodule

bind collectorTop collectorTopChecker portCheck (
    .clk        (clk),
    .rstN       (rstN),
    .writeValid (writeValid),
    .writeReq   (writeReq),
    .readValid  (readValid),
    .resultValid(resultValid),
    .result     (result)
);

// File: tb/collectorTb.sv
`timescale 1ns/1ps

module collectorTb import collectorPkg::*; ();

    logic                  clk;
    logic                  rstN;
    logic                  writeValid;
    collectWriteT          writeReq;
    logic                  readValid;
    logic [ADDR_WIDTH-1:0] readAddr;
    logic                  resultValid;
    collectResultT         result;

    // op word: code, write addr, slot, exponent, read addr, sum, count
    logic [83:0]   opMem [64];
    collectResultT expQ [$];
    int            opCount = 0;
    int            errCount = 0;
    int            warnCount = 0;

    collectorTop UUT (
        .clk        (clk),
        .rstN       (rstN),
        .writeValid (writeValid),
        .writeReq   (writeReq),
        .readValid  (readValid),
        .readAddr   (readAddr),
        .resultValid(resultValid),
        .result     (result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic driveOp(input logic [83:0] op);
        logic [3:0]    code;
        collectWriteT  req;
        collectResultT expected;
        code              = op[83:80];
        req.rowAddr       = op[79:68];
        req.slotIndex     = op[66:64];
        req.exponent      = op[61:56];
        expected.sum      = op[42:4];
        expected.count    = op[2:0];
        writeReq <= req;
        readAddr <= op[55:44];
        if (code > 4'h3) begin
            warnCount++;
            $display("warning: unknown op code %0h treated as idle", code);
            writeValid <= 1'b0;
            readValid  <= 1'b0;
        end else begin
            writeValid <= code[0];
            readValid  <= code[1];
            // expected result is due READ_LATENCY cycles from now
            if (code[1]) begin
                expQ.push_back(expected);
            end
        end
    endtask

    initial begin
        int count;
        rstN       <= 1'b0;
        writeValid <= 1'b0;
        writeReq   <= '0;
        readValid  <= 1'b0;
        readAddr   <= '0;
        // all ones marks the end of the list
        for (int i = 0; i < 64; i++) begin
            opMem[i] = '1;
        end
        $readmemh("tb/collectorInput.txt", opMem);
        count = 0;
        while (count < 64 && opMem[count][83:80] != 4'hf) begin
            count++;
        end
        opCount = count;
        assert (opCount > 0) else begin
            errCount++;
            $display("no operations were loaded from tb/collectorInput.txt");
        end
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        for (int i = 0; i < opCount; i++) begin
            @(posedge clk);
            driveOp(opMem[i]);
        end
        @(posedge clk);
        writeValid <= 1'b0;
        readValid  <= 1'b0;
        while (expQ.size() != 0) begin
            @(posedge clk);
        end
        repeat (READ_LATENCY + 2) @(posedge clk);
        $display("errors %0d warnings %0d", errCount, warnCount);
        if (errCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        collectResultT expected;
        if (resultValid) begin
            assert (expQ.size() != 0) else begin
                errCount++;
                $display("a result came out at %0t with no read waiting for it", $time);
            end
            if (expQ.size() != 0) begin
                expected = expQ.pop_front();
                assert (result == expected) else begin
                    errCount++;
                    $display("ERR %0t: got sum %0h count %0d, expected sum %0h count %0d",
                             $time, result.sum, result.count, expected.sum, expected.count);
                end
            end
        end
    end

    initial begin
        wait (opCount > 0);
        repeat (opCount + READ_LATENCY + 20) @(posedge clk);
        $display("timeout: read results never arrived, %0d still outstanding", expQ.size());
        $display("errors %0d warnings %0d", errCount, warnCount);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: tb/collectorInput.txt
// columns: op(0 idle 1 write 2 read 3 write+read) _ wAddr _ slot _ exp _ rAddr _ sum _ count
// all hex; sum and count are the expected result of the read
1_005_0_00_000_0000000000_0
1_005_1_01_000_0000000000_0
1_005_2_02_000_0000000000_0
1_005_3_03_000_0000000000_0
1_005_4_04_000_0000000000_0
1_005_5_05_000_0000000000_0
1_40a_0_0a_000_0000000000_0
1_40a_1_0b_000_0000000000_0
1_40a_2_0c_000_0000000000_0
1_40a_3_0d_000_0000000000_0
1_40a_4_0e_000_0000000000_0
1_40a_5_23_000_0000000000_0
1_80f_0_23_000_0000000000_0
1_80f_1_23_000_0000000000_0
1_80f_2_23_000_0000000000_0
1_80f_3_23_000_0000000000_0
1_80f_4_23_000_0000000000_0
1_80f_5_23_000_0000000000_0
1_c11_0_14_000_0000000000_0
1_c11_1_15_000_0000000000_0
1_c11_2_16_000_0000000000_0
1_c11_3_17_000_0000000000_0
1_c11_4_18_000_0000000000_0
1_c11_5_19_000_0000000000_0
// full rows, one per bank, back to back
2_000_0_00_005_000000003f_6
2_000_0_00_40a_0800007c00_6
2_000_0_00_80f_3000000000_6
2_000_0_00_c11_0003f00000_6
3_40a_3_23_005_0000000000_0
1_80f_2_05_000_0000000000_0
1_80f_2_09_000_0000000000_0
// write into the bank being read is dropped
3_c11_1_07_c11_0000000000_0
2_000_0_00_40a_0800000000_1
2_000_0_00_80f_0000000200_1
0_000_0_00_000_0000000000_0
2_000_0_00_c11_0000000000_0
2_000_0_00_40a_0000000000_0

// File: flist.f
common/collectorPkg.sv
collector/maskedDualPortRam.sv
collector/collectorBank.sv
collector/collectionArray.sv
source/slotDecoder.sv
source/termSummer.sv
source/collectorTop.sv
tb/collectorTop_checker.sv
tb/collectorTb.sv

// File: run.sh
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module collectorTb -o collectorSim
./obj_dir/collectorSim | tee sim.log

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
exit 0
